// ==== logic/alu_execute.sv ====
// Execute stage
// ALU on rs and rt or the immediate, load/store address generation
// and resolution of branch and jump targets into one next PC
module alu_execute (
    decode_if.execute       dec,
    input  mips_pkg::word_t rs_data,
    input  mips_pkg::word_t rt_data,
    input  mips_pkg::word_t pc,
    output mips_pkg::word_t alu_result,
    output mips_pkg::word_t eff_addr,
    output mips_pkg::word_t next_pc
);

    mips_pkg::word_t op_b;
    mips_pkg::word_t pc_plus4;
    mips_pkg::word_t branch_target;
    mips_pkg::word_t jump_target;
    logic            operands_equal;

    assign op_b           = dec.use_imm ? dec.imm_ext : rt_data;
    assign pc_plus4       = pc + 32'd4;
    assign branch_target  = pc_plus4 + {dec.imm_ext[29:0], 2'b00};   // Word offset
    assign jump_target    = {pc_plus4[31:28], dec.imm_ext[25:0], 2'b00};
    assign operands_equal = (rs_data == rt_data);
    assign eff_addr       = rs_data + dec.imm_ext;

    always_comb begin
        case (dec.alu_op)
            mips_pkg::ALU_SUB:  alu_result = rs_data - op_b;
            mips_pkg::ALU_AND:  alu_result = rs_data & op_b;
            mips_pkg::ALU_OR:   alu_result = rs_data | op_b;
            mips_pkg::ALU_XOR:  alu_result = rs_data ^ op_b;
            mips_pkg::ALU_SLT:  alu_result = {31'b0, $signed(rs_data) < $signed(op_b)};
            mips_pkg::ALU_SLTU: alu_result = {31'b0, rs_data < op_b};
            // Shifts act on rt by the shamt field
            mips_pkg::ALU_SLL:  alu_result = rt_data << dec.shamt;
            mips_pkg::ALU_SRL:  alu_result = rt_data >> dec.shamt;
            mips_pkg::ALU_SRA:  alu_result = $signed(rt_data) >>> dec.shamt;
            mips_pkg::ALU_LUI:  alu_result = {op_b[15:0], 16'b0};
            default:            alu_result = rs_data + op_b;   // ADDU, ADDIU
        endcase
    end

    // No delay slot, so taken flow replaces PC + 4 directly
    always_comb begin
        case (dec.flow)
            mips_pkg::FLOW_BEQ:  next_pc = operands_equal ? branch_target : pc_plus4;
            mips_pkg::FLOW_BNE:  next_pc = operands_equal ? pc_plus4 : branch_target;
            mips_pkg::FLOW_JUMP: next_pc = dec.jump_reg ? rs_data : jump_target;
            default:             next_pc = pc_plus4;
        endcase
    end

endmodule

// ==== logic/bus_sequencer.sv ====
// Bus sequencer
// FETCH/EXEC/MEM/HALT state machine owning PC and the instruction register,
// drives the Avalon master and holds each transfer through waitrequest
`include "mips_macros.svh"

module bus_sequencer (
    input  logic                 clk,
    input  logic                 reset,
    decode_if.sequencer          dec,
    input  mips_pkg::word_t      next_pc,
    input  mips_pkg::word_t      eff_addr,
    input  mips_pkg::word_t      rt_data,
    input  mips_pkg::word_t      readdata,
    output mips_pkg::word_t      instr,
    output mips_pkg::word_t      pc,
    output logic                 exec_phase,
    output logic                 load_phase,
    output logic [1:0]           byte_sel,
    output logic                 active,
    output mips_pkg::word_t      address,
    output logic                 read,
    output logic                 write,
    input  logic                 waitrequest,
    output mips_pkg::word_t      writedata,
    output mips_pkg::byte_en_t   byteenable
);

    mips_pkg::cpu_state_t state;
    mips_pkg::word_t      mem_addr;     // Latched effective address
    mips_pkg::word_t      store_data;
    mips_pkg::byte_en_t   mem_be;
    logic                 mem_access;

    assign mem_access = dec.is_load | dec.is_store;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= mips_pkg::FETCH;
            pc    <= `MIPS_RESET_VECTOR;
            instr <= '0;                                // Decodes as a no-op
        end else begin
            case (state)
                mips_pkg::FETCH: begin
                    if (pc == '0) begin
                        state <= mips_pkg::HALT;        // Halt without touching the bus
                    end else if (!waitrequest) begin
                        instr <= readdata;
                        state <= mips_pkg::EXEC;
                    end
                end
                mips_pkg::EXEC: begin
                    if (mem_access) begin
                        state <= mips_pkg::MEM;
                    end else begin
                        pc    <= next_pc;
                        state <= mips_pkg::FETCH;
                    end
                end
                mips_pkg::MEM: begin
                    if (!waitrequest) begin
                        pc    <= pc + 32'd4;
                        state <= mips_pkg::FETCH;
                    end
                end
                default: state <= mips_pkg::HALT;       // Stays until reset
            endcase
        end
    end

    // Memory transfer payload captured at the end of EXEC
    always_ff @(posedge clk) begin
        if (state == mips_pkg::EXEC) begin
            mem_addr   <= eff_addr;
            store_data <= dec.byte_access ? {4{rt_data[7:0]}} : rt_data;   // SB replicates
            mem_be     <= dec.byte_access ? mips_pkg::byte_en_t'(1) << eff_addr[1:0] : '1;
        end
    end

    assign active     = (state != mips_pkg::HALT);
    assign exec_phase = (state == mips_pkg::EXEC);
    assign load_phase = (state == mips_pkg::MEM) && dec.is_load && !waitrequest;
    assign byte_sel   = mem_addr[1:0];

    // Avalon master, all of it decoded from registers so held while stalled
    assign read       = ((state == mips_pkg::FETCH) && (pc != '0)) ||
                        ((state == mips_pkg::MEM) && dec.is_load);
    assign write      = (state == mips_pkg::MEM) && dec.is_store;
    assign address    = (state == mips_pkg::MEM) ? mem_addr : pc;
    assign byteenable = (state == mips_pkg::MEM) ? mem_be : '1;  // Fetch is full word
    assign writedata  = store_data;

endmodule

// ==== logic/decode_if.sv ====
// Decoded control bundle
// Driven by the decode stage, read by execute, result and bus sequencer
interface decode_if;

    mips_pkg::alu_op_t   alu_op;
    mips_pkg::reg_addr_t rs;
    mips_pkg::reg_addr_t rt;
    mips_pkg::reg_addr_t dest;        // rd for R-type, rt otherwise
    mips_pkg::shamt_t    shamt;
    mips_pkg::word_t     imm_ext;     // Extended immediate or J index
    logic                use_imm;
    mips_pkg::flow_t     flow;
    logic                jump_reg;    // JR takes target from rs
    logic                reg_write;
    logic                is_load;
    logic                is_store;
    logic                byte_access; // LBU and SB

    modport decode (output alu_op, rs, rt, dest, shamt, imm_ext, use_imm, flow,
                    jump_reg, reg_write, is_load, is_store, byte_access);
    modport execute (input alu_op, shamt, imm_ext, use_imm, flow, jump_reg);
    modport result (input dest, reg_write, is_load, byte_access);
    modport sequencer (input is_load, is_store, byte_access);

endinterface

// ==== logic/instr_decode.sv ====
// Instruction decode stage
// Splits the instruction word into fields and maps opcode and function
// code onto control fields, unknown encodings become no-ops
module instr_decode (
    input  mips_pkg::word_t instr,
    decode_if.decode        dec
);

    mips_pkg::opcode_t opcode;
    mips_pkg::funct_t  funct;
    logic [15:0]       imm;

    assign opcode = mips_pkg::opcode_t'(instr[31:26]);
    assign funct  = mips_pkg::funct_t'(instr[5:0]);
    assign imm    = instr[15:0];

    always_comb begin
        // Field split and no-op defaults
        dec.rs          = instr[25:21];
        dec.rt          = instr[20:16];
        dec.dest        = instr[20:16];
        dec.shamt       = instr[10:6];
        dec.imm_ext     = {{16{imm[15]}}, imm};   // Sign extend unless overridden
        dec.alu_op      = mips_pkg::ALU_ADD;
        dec.use_imm     = 1'b1;
        dec.flow        = mips_pkg::FLOW_SEQ;
        dec.jump_reg    = 1'b0;
        dec.reg_write   = 1'b0;
        dec.is_load     = 1'b0;
        dec.is_store    = 1'b0;
        dec.byte_access = 1'b0;
        case (opcode)
            mips_pkg::OP_RTYPE: begin
                dec.dest      = instr[15:11];
                dec.use_imm   = 1'b0;
                dec.reg_write = 1'b1;
                case (funct)
                    mips_pkg::FN_ADDU: dec.alu_op = mips_pkg::ALU_ADD;
                    mips_pkg::FN_SUBU: dec.alu_op = mips_pkg::ALU_SUB;
                    mips_pkg::FN_AND:  dec.alu_op = mips_pkg::ALU_AND;
                    mips_pkg::FN_OR:   dec.alu_op = mips_pkg::ALU_OR;
                    mips_pkg::FN_XOR:  dec.alu_op = mips_pkg::ALU_XOR;
                    mips_pkg::FN_SLT:  dec.alu_op = mips_pkg::ALU_SLT;
                    mips_pkg::FN_SLTU: dec.alu_op = mips_pkg::ALU_SLTU;
                    mips_pkg::FN_SLL:  dec.alu_op = mips_pkg::ALU_SLL;
                    mips_pkg::FN_SRL:  dec.alu_op = mips_pkg::ALU_SRL;
                    mips_pkg::FN_SRA:  dec.alu_op = mips_pkg::ALU_SRA;
                    mips_pkg::FN_JR: begin
                        dec.reg_write = 1'b0;
                        dec.flow      = mips_pkg::FLOW_JUMP;
                        dec.jump_reg  = 1'b1;
                    end
                    default: dec.reg_write = 1'b0;       // Unknown funct is a no-op
                endcase
            end
            mips_pkg::OP_J: begin
                dec.flow    = mips_pkg::FLOW_JUMP;
                dec.imm_ext = {6'b0, instr[25:0]};       // Carries the jump index
            end
            mips_pkg::OP_BEQ: begin
                dec.flow    = mips_pkg::FLOW_BEQ;
                dec.use_imm = 1'b0;
            end
            mips_pkg::OP_BNE: begin
                dec.flow    = mips_pkg::FLOW_BNE;
                dec.use_imm = 1'b0;
            end
            mips_pkg::OP_ADDIU: dec.reg_write = 1'b1;
            mips_pkg::OP_SLTI: begin
                dec.alu_op    = mips_pkg::ALU_SLT;
                dec.reg_write = 1'b1;
            end
            mips_pkg::OP_SLTIU: begin
                dec.alu_op    = mips_pkg::ALU_SLTU;      // Still sign extended
                dec.reg_write = 1'b1;
            end
            mips_pkg::OP_ANDI, mips_pkg::OP_ORI, mips_pkg::OP_XORI: begin
                dec.imm_ext   = {16'b0, imm};            // Logical ops zero extend
                dec.reg_write = 1'b1;
                case (opcode)
                    mips_pkg::OP_ANDI: dec.alu_op = mips_pkg::ALU_AND;
                    mips_pkg::OP_ORI:  dec.alu_op = mips_pkg::ALU_OR;
                    default:           dec.alu_op = mips_pkg::ALU_XOR;
                endcase
            end
            mips_pkg::OP_LUI: begin
                dec.alu_op    = mips_pkg::ALU_LUI;
                dec.reg_write = 1'b1;
            end
            mips_pkg::OP_LW: begin
                dec.is_load   = 1'b1;
                dec.reg_write = 1'b1;
            end
            mips_pkg::OP_LBU: begin
                dec.is_load     = 1'b1;
                dec.reg_write   = 1'b1;
                dec.byte_access = 1'b1;
            end
            mips_pkg::OP_SW: dec.is_store = 1'b1;
            mips_pkg::OP_SB: begin
                dec.is_store    = 1'b1;
                dec.byte_access = 1'b1;
            end
            default: ;                                   // No-op
        endcase
    end

endmodule

// ==== logic/mips_cpu_bus.sv ====
// MIPS CPU with Avalon master bus
// Multicycle core, one instruction in flight, halts when PC reaches 0
`include "mips_macros.svh"

module mips_cpu_bus (
    input  logic                        clk,
    input  logic                        reset,
    output logic                        active,
    output logic [`MIPS_WORD_W-1:0]     register_v0,
    output logic [`MIPS_WORD_W-1:0]     address,
    output logic                        write,
    output logic                        read,
    input  logic                        waitrequest,
    output logic [`MIPS_WORD_W-1:0]     writedata,
    output logic [`MIPS_BYTE_LANES-1:0] byteenable,
    input  logic [`MIPS_WORD_W-1:0]     readdata
);

    decode_if dec ();

    mips_pkg::word_t     instr, pc, next_pc, eff_addr, alu_result;
    mips_pkg::word_t     rs_data, rt_data, wr_data;
    mips_pkg::reg_addr_t wr_addr;
    logic                wr_en, exec_phase, load_phase;
    logic [1:0]          byte_sel;

    instr_decode u_decode (.instr(instr), .dec(dec.decode));

    reg_file u_regs (
        .clk(clk), .reset(reset),
        .rs(dec.rs), .rt(dec.rt), .rs_data(rs_data), .rt_data(rt_data),
        .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data), .v0(register_v0)
    );

    alu_execute u_execute (
        .dec(dec.execute), .rs_data(rs_data), .rt_data(rt_data), .pc(pc),
        .alu_result(alu_result), .eff_addr(eff_addr), .next_pc(next_pc)
    );

    writeback_select u_result (
        .dec(dec.result), .alu_result(alu_result), .load_data(readdata),
        .byte_sel(byte_sel), .exec_phase(exec_phase), .load_phase(load_phase),
        .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data)
    );

    bus_sequencer u_sequencer (
        .clk(clk), .reset(reset), .dec(dec.sequencer),
        .next_pc(next_pc), .eff_addr(eff_addr), .rt_data(rt_data), .readdata(readdata),
        .instr(instr), .pc(pc), .exec_phase(exec_phase), .load_phase(load_phase),
        .byte_sel(byte_sel), .active(active), .address(address), .read(read),
        .write(write), .waitrequest(waitrequest), .writedata(writedata),
        .byteenable(byteenable)
    );

endmodule

// ==== logic/mips_macros.svh ====
// MIPS CPU shared constants
// Widths, reset vector and special register numbers used across the core
`ifndef MIPS_MACROS_SVH
`define MIPS_MACROS_SVH

// Datapath and bus width
`define MIPS_WORD_W 32

// General purpose register count
`define MIPS_REG_COUNT 32

// First instruction fetched after reset
`define MIPS_RESET_VECTOR 32'hBFC00000

// Result register brought out as register_v0
`define MIPS_REG_V0 5'd2

// Avalon byte lanes in one word
`define MIPS_BYTE_LANES 4

`endif

// ==== logic/mips_pkg.sv ====
// MIPS CPU package
// Opcode and function-code encodings, ALU and flow kinds, FSM states
// and the datapath vector types
`include "mips_macros.svh"

package mips_pkg;

    typedef logic [`MIPS_WORD_W-1:0] word_t;                  // Data or address word
    typedef logic [$clog2(`MIPS_REG_COUNT)-1:0] reg_addr_t;   // Register number
    typedef logic [4:0] shamt_t;                              // Shift amount field
    typedef logic [`MIPS_BYTE_LANES-1:0] byte_en_t;           // Avalon byteenable

    // Primary opcodes still supported
    typedef enum logic [5:0] {
        OP_RTYPE = 6'd0,
        OP_J     = 6'd2,
        OP_BEQ   = 6'd4,
        OP_BNE   = 6'd5,
        OP_ADDIU = 6'd9,
        OP_SLTI  = 6'd10,
        OP_SLTIU = 6'd11,
        OP_ANDI  = 6'd12,
        OP_ORI   = 6'd13,
        OP_XORI  = 6'd14,
        OP_LUI   = 6'd15,
        OP_LW    = 6'd35,
        OP_LBU   = 6'd36,
        OP_SB    = 6'd40,
        OP_SW    = 6'd43
    } opcode_t;

    // R-type function codes
    typedef enum logic [5:0] {
        FN_SLL  = 6'd0,
        FN_SRL  = 6'd2,
        FN_SRA  = 6'd3,
        FN_JR   = 6'd8,
        FN_ADDU = 6'd33,
        FN_SUBU = 6'd35,
        FN_AND  = 6'd36,
        FN_OR   = 6'd37,
        FN_XOR  = 6'd38,
        FN_SLT  = 6'd42,
        FN_SLTU = 6'd43
    } funct_t;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT,
        ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI
    } alu_op_t;

    // How the next PC is picked
    typedef enum logic [1:0] {
        FLOW_SEQ,
        FLOW_BEQ,
        FLOW_BNE,
        FLOW_JUMP
    } flow_t;

    typedef enum logic [1:0] {
        FETCH,
        EXEC,
        MEM,
        HALT
    } cpu_state_t;

endpackage

// ==== logic/reg_file.sv ====
// General purpose register file
// 32 entries, two combinational read ports and one write port,
// register 0 reads as zero and v0 is tapped out continuously
`include "mips_macros.svh"

module reg_file (
    input  logic                clk,
    input  logic                reset,
    input  mips_pkg::reg_addr_t rs,
    input  mips_pkg::reg_addr_t rt,
    output mips_pkg::word_t     rs_data,
    output mips_pkg::word_t     rt_data,
    input  logic                wr_en,
    input  mips_pkg::reg_addr_t wr_addr,
    input  mips_pkg::word_t     wr_data,
    output mips_pkg::word_t     v0
);

    mips_pkg::word_t regs [`MIPS_REG_COUNT];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `MIPS_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && wr_addr != '0) begin  // $zero stays zero
            regs[wr_addr] <= wr_data;
        end
    end

    assign rs_data = regs[rs];
    assign rt_data = regs[rt];
    assign v0      = regs[`MIPS_REG_V0];

endmodule

// ==== logic/writeback_select.sv ====
// Result stage
// Picks the ALU result or the aligned load data for the register file
// and qualifies the write with the current phase
module writeback_select (
    decode_if.result            dec,
    input  mips_pkg::word_t     alu_result,
    input  mips_pkg::word_t     load_data,
    input  logic [1:0]          byte_sel,
    input  logic                exec_phase,
    input  logic                load_phase,
    output logic                wr_en,
    output mips_pkg::reg_addr_t wr_addr,
    output mips_pkg::word_t     wr_data
);

    logic [7:0]      lane_byte;
    mips_pkg::word_t load_value;

    assign lane_byte  = load_data[8*byte_sel +: 8];    // Lane picked by address bits 1:0
    assign load_value = dec.byte_access ? {24'b0, lane_byte} : load_data;

    assign wr_addr = dec.dest;
    assign wr_data = load_phase ? load_value : alu_result;

    // Loads write in MEM, everything else at the end of EXEC
    assign wr_en = dec.reg_write &
                   ((load_phase & dec.is_load) | (exec_phase & ~dec.is_load));

endmodule

// ==== mips_cpu_bus.f ====
+incdir+logic
logic/mips_pkg.sv
logic/decode_if.sv
logic/instr_decode.sv
logic/reg_file.sv
logic/alu_execute.sv
logic/writeback_select.sv
logic/bus_sequencer.sv
logic/mips_cpu_bus.sv
sim/mips_cpu_bus_assert.sv
sim/mips_cpu_bus_tb.sv

// ==== sim/mips_cpu_bus_assert.sv ====
// Avalon master protocol checks for the MIPS CPU
// Bound into the CPU top level, watches command overlap, request hold
// under waitrequest and bus silence after halt
`include "mips_macros.svh"

module mips_cpu_bus_assert (
    input logic                        clk,
    input logic                        reset,
    input logic                        active,
    input logic                        read,
    input logic                        write,
    input logic                        waitrequest,
    input logic [`MIPS_WORD_W-1:0]     address,
    input logic [`MIPS_WORD_W-1:0]     writedata,
    input logic [`MIPS_BYTE_LANES-1:0] byteenable
);
    timeunit 1ns;
    timeprecision 100ps;

    int failures = 0;    // Assertion failures so far

    // Never a read and a write in the same cycle
    one_command: assert property (@(posedge clk) disable iff (reset)
        !(read && write))
        else begin
            failures++;
            $error("read and write asserted together");
        end

    // Stalled request keeps command, address and payload
    held_request: assert property (@(posedge clk) disable iff (reset)
        (read || write) && waitrequest |=>
            $stable(address) && $stable(read) && $stable(write) &&
            $stable(byteenable) && (!write || $stable(writedata)))
        else begin
            failures++;
            $error("request changed while waitrequest was high");
        end

    // Halted core stays off the bus
    quiet_when_halted: assert property (@(posedge clk) disable iff (reset)
        !active |-> !read && !write)
        else begin
            failures++;
            $error("bus command while the CPU is halted");
        end

endmodule

// ==== sim/mips_cpu_bus_tb.sv ====
// Testbench for the MIPS CPU with Avalon master bus
// Runs a table of short programs from the reset vector against a memory
// model with random waitrequest stretches, then checks v0 and the data word
`include "mips_macros.svh"

module mips_cpu_bus_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int n_tests      = 9;
    localparam int prog_len     = 10;     // Words per program including the final JR
    localparam int halt_timeout = 500;    // Cycles allowed per program
    localparam int halt_hold    = 6;      // Cycles watched after halt
    localparam logic [31:0] data_addr = 32'h0000_0100;

    // MIPS encodings
    localparam logic [5:0] op_j = 6'd2, op_beq = 6'd4, op_bne = 6'd5, op_addiu = 6'd9,
        op_slti = 6'd10, op_sltiu = 6'd11, op_andi = 6'd12, op_ori = 6'd13,
        op_xori = 6'd14, op_lui = 6'd15, op_lw = 6'd35, op_lbu = 6'd36,
        op_sb = 6'd40, op_sw = 6'd43;
    localparam logic [5:0] fn_sll = 6'd0, fn_srl = 6'd2, fn_sra = 6'd3, fn_jr = 6'd8,
        fn_addu = 6'd33, fn_subu = 6'd35, fn_and = 6'd36, fn_or = 6'd37,
        fn_xor = 6'd38, fn_slt = 6'd42, fn_sltu = 6'd43;
    localparam logic [4:0] r0 = 5'd0, v0 = 5'd2, t0 = 5'd8, t1 = 5'd9, t2 = 5'd10,
        t3 = 5'd11, t4 = 5'd12, t5 = 5'd13, ra = 5'd31;

    logic        clk, reset, active, write, read, waitrequest;
    logic [31:0] register_v0, address, writedata, readdata;
    logic [3:0]  byteenable;

    // Program table and expected results
    logic [31:0] prog_tab [n_tests][prog_len];
    logic [31:0] data_tab [n_tests];
    logic [31:0] exp_v0_tab [n_tests];
    logic [31:0] exp_mem_tab [n_tests];
    string       name_tab [n_tests];
    int          fill_idx, fill_len;

    // Memory model state
    logic [31:0] prog_mem [prog_len];
    logic [31:0] data_word;                   // Single data word at data_addr
    logic        in_xfer;
    int          stall_left;
    logic [31:0] lcg_state;
    logic        req_valid, req_write;
    logic [31:0] req_addr, req_wdata;
    logic [3:0]  req_be;

    int errors, checks, timeouts, cur_test;

    mips_cpu_bus DUT (
        .clk(clk), .reset(reset), .active(active), .register_v0(register_v0),
        .address(address), .write(write), .read(read), .waitrequest(waitrequest),
        .writedata(writedata), .byteenable(byteenable), .readdata(readdata)
    );

    bind mips_cpu_bus mips_cpu_bus_assert u_bus_assert (
        .clk(clk), .reset(reset), .active(active), .read(read), .write(write),
        .waitrequest(waitrequest), .address(address), .writedata(writedata),
        .byteenable(byteenable)
    );

    always #20 clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // Field order as in the instruction word
    function automatic logic [31:0] enc_r(input logic [5:0] funct, input logic [4:0] rs,
                                          input logic [4:0] rt, input logic [4:0] rd,
                                          input logic [4:0] sh);
        return {6'd0, rs, rt, rd, sh, funct};
    endfunction

    function automatic logic [31:0] enc_i(input logic [5:0] op, input logic [4:0] rs,
                                          input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] enc_j(input logic [5:0] op, input logic [31:0] target);
        return {op, target[27:2]};            // Word index within the 256 MB region
    endfunction

    function automatic logic [31:0] read_word(input logic [31:0] addr);
        logic [31:0] offset;
        offset = addr - `MIPS_RESET_VECTOR;
        if (addr[31:2] == data_addr[31:2]) begin
            return data_word;
        end else if (offset < prog_len * 4) begin
            return prog_mem[offset[31:2]];
        end
        return 32'h0;                         // Unmapped space reads as a no-op
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("ERR %0d ns test %0d %s got %h expected %h",
                     $time, cur_test, name, actual, expected);
        end
    endtask

    task automatic store_word();
        if (req_addr[31:2] != data_addr[31:2]) begin
            errors++;
            $display("store to unmapped address %h in test %0d", req_addr, cur_test);
        end else begin
            for (int b = 0; b < `MIPS_BYTE_LANES; b++) begin
                if (req_be[b]) begin
                    data_word[8*b +: 8] = req_wdata[8*b +: 8];   // Only enabled lanes
                end
            end
        end
    endtask

    // Bus request as held in the middle of the cycle
    always @(negedge clk) begin
        req_valid <= (read === 1'b1) || (write === 1'b1);
        req_write <= (write === 1'b1);
        req_addr  <= address;
        req_wdata <= writedata;
        req_be    <= byteenable;
    end

    // Avalon slave answering just after each rising edge
    always @(posedge clk) begin
        #1;
        if (req_valid && !waitrequest) begin  // Transfer finished on this edge
            in_xfer = 1'b0;
            if (req_write) begin
                store_word();
            end
        end
        if (read !== 1'b1 && write !== 1'b1) begin
            in_xfer = 1'b0;
        end else if (!in_xfer) begin
            in_xfer    = 1'b1;                // New request draws its stall
            lcg_state  = lcg_next(lcg_state);
            stall_left = lcg_state[17:16];    // 0 to 3 wait cycles
        end
        if (in_xfer && stall_left > 0) begin
            waitrequest = 1'b1;
            stall_left--;
        end else begin
            waitrequest = 1'b0;
        end
        readdata = read_word(address);
    end

    task automatic add_instr(input logic [31:0] word);
        prog_tab[fill_idx][fill_len] = word;
        fill_len++;
    endtask

    task automatic close_entry(input string name, input logic [31:0] data_init,
                               input logic [31:0] v0_exp, input logic [31:0] mem_exp);
        add_instr(enc_r(fn_jr, ra, r0, r0, 5'd0));   // $ra holds 0 so PC goes to 0
        name_tab[fill_idx]    = name;
        data_tab[fill_idx]    = data_init;
        exp_v0_tab[fill_idx]  = v0_exp;
        exp_mem_tab[fill_idx] = mem_exp;
        fill_idx++;
        fill_len = 0;
    endtask

    task automatic build_table();
        for (int i = 0; i < n_tests; i++) begin
            for (int j = 0; j < prog_len; j++) begin
                prog_tab[i][j] = 32'h0;
            end
        end
        fill_idx = 0;
        fill_len = 0;
        // 100 minus 30 then a write to $zero
        add_instr(enc_i(op_addiu, r0, t0, 16'd100));
        add_instr(enc_i(op_addiu, r0, t1, 16'd30));
        add_instr(enc_r(fn_subu, t0, t1, v0, 5'd0));
        add_instr(enc_r(fn_addu, t0, t1, r0, 5'd0));  // Dropped
        add_instr(enc_r(fn_addu, v0, r0, v0, 5'd0));  // $zero must read 0
        close_entry("addu subu", 32'h0bad_f00d, 32'd70, 32'h0bad_f00d);
        // Logical ops on 0x0f0f and 0x00ff
        add_instr(enc_i(op_addiu, r0, t0, 16'h0f0f));
        add_instr(enc_i(op_addiu, r0, t1, 16'h00ff));
        add_instr(enc_r(fn_and, t0, t1, t2, 5'd0));   // 0x000f
        add_instr(enc_r(fn_or, t0, t1, t3, 5'd0));    // 0x0fff
        add_instr(enc_r(fn_xor, t3, t0, t4, 5'd0));   // 0x00f0
        add_instr(enc_r(fn_or, t4, t2, v0, 5'd0));
        close_entry("logic", 32'h1357_9bdf, 32'h0000_00ff, 32'h1357_9bdf);
        // -1 against 1 signed and unsigned
        add_instr(enc_i(op_addiu, r0, t0, 16'hffff));
        add_instr(enc_i(op_addiu, r0, t1, 16'd1));
        add_instr(enc_r(fn_slt, t0, t1, t2, 5'd0));   // 1
        add_instr(enc_r(fn_sltu, t0, t1, t3, 5'd0));  // 0
        add_instr(enc_r(fn_sltu, t1, t0, t4, 5'd0));  // 1
        add_instr(enc_r(fn_sll, r0, t2, t2, 5'd4));
        add_instr(enc_r(fn_or, t2, t3, v0, 5'd0));
        add_instr(enc_r(fn_addu, v0, t4, v0, 5'd0));
        close_entry("slt sltu", 32'h2468_ace0, 32'h0000_0011, 32'h2468_ace0);
        // Arithmetic and logical shifts of 0x80000000
        add_instr(enc_i(op_lui, r0, t0, 16'h8000));
        add_instr(enc_r(fn_sra, r0, t0, t1, 5'd4));   // 0xf8000000
        add_instr(enc_r(fn_srl, r0, t0, t2, 5'd4));   // 0x08000000
        add_instr(enc_r(fn_subu, t1, t2, t3, 5'd0));
        add_instr(enc_i(op_addiu, r0, t4, 16'd3));
        add_instr(enc_r(fn_sll, r0, t4, t4, 5'd8));
        add_instr(enc_r(fn_or, t3, t4, v0, 5'd0));
        close_entry("shifts", 32'h3c3c_3c3c, 32'hf000_0300, 32'h3c3c_3c3c);
        // Sign versus zero extension of immediates
        add_instr(enc_i(op_addiu, r0, t0, 16'hfffb));  // -5
        add_instr(enc_i(op_andi, t0, t1, 16'hffff));   // 0x0000fffb
        add_instr(enc_i(op_xori, t1, t2, 16'h8001));   // 0x00007ffa
        add_instr(enc_i(op_slti, t0, t3, 16'hfffc));   // -5 < -4
        add_instr(enc_i(op_sltiu, t0, t4, 16'd5));     // Huge unsigned so 0
        add_instr(enc_i(op_ori, r0, t5, 16'h8000));
        add_instr(enc_r(fn_addu, t2, t3, v0, 5'd0));
        add_instr(enc_r(fn_addu, v0, t4, v0, 5'd0));
        add_instr(enc_r(fn_addu, v0, t5, v0, 5'd0));
        close_entry("immediates", 32'h4d4d_4d4d, 32'h0000_fffb, 32'h4d4d_4d4d);
        // Word store then load back
        add_instr(enc_i(op_addiu, r0, t0, data_addr[15:0]));
        add_instr(enc_i(op_lui, r0, t1, 16'hcafe));
        add_instr(enc_i(op_ori, t1, t1, 16'hbabe));
        add_instr(enc_i(op_sw, t0, t1, 16'd0));
        add_instr(enc_i(op_addiu, r0, t1, 16'd0));     // Clear the source
        add_instr(enc_i(op_lw, t0, v0, 16'd0));
        close_entry("sw lw", 32'h5a5a_5a5a, 32'hcafe_babe, 32'hcafe_babe);
        // Byte store into lane 2 and byte loads
        add_instr(enc_i(op_addiu, r0, t0, data_addr[15:0]));
        add_instr(enc_i(op_addiu, r0, t1, 16'h01a5));
        add_instr(enc_i(op_sb, t0, t1, 16'd2));
        add_instr(enc_i(op_lbu, t0, v0, 16'd2));       // 0xa5 without sign
        add_instr(enc_i(op_lbu, t0, t2, 16'd3));       // 0x11
        add_instr(enc_r(fn_sll, r0, t2, t2, 5'd8));
        add_instr(enc_r(fn_or, v0, t2, v0, 5'd0));
        close_entry("sb lbu", 32'h1122_3344, 32'h0000_11a5, 32'h11a5_3344);
        // Taken and untaken branches
        add_instr(enc_i(op_addiu, r0, t0, 16'd5));
        add_instr(enc_i(op_addiu, r0, t1, 16'd5));
        add_instr(enc_i(op_addiu, r0, v0, 16'd1));
        add_instr(enc_i(op_beq, t0, t1, 16'd1));       // Taken
        add_instr(enc_i(op_addiu, r0, v0, 16'd99));
        add_instr(enc_i(op_bne, t0, t1, 16'd1));       // Falls through
        add_instr(enc_i(op_addiu, v0, v0, 16'd2));
        add_instr(enc_i(op_bne, t0, r0, 16'd1));       // Taken
        add_instr(enc_i(op_addiu, r0, v0, 16'd77));
        close_entry("branches", 32'h6e6e_6e6e, 32'd3, 32'h6e6e_6e6e);
        // Jump over one word then an untaken beq
        add_instr(enc_i(op_addiu, r0, v0, 16'd7));
        add_instr(enc_j(op_j, `MIPS_RESET_VECTOR + 32'd12));
        add_instr(enc_i(op_addiu, r0, v0, 16'd55));
        add_instr(enc_i(op_beq, v0, r0, 16'd1));
        add_instr(enc_i(op_addiu, v0, v0, 16'd1));
        close_entry("jump", 32'h7f7f_7f7f, 32'd8, 32'h7f7f_7f7f);
    endtask

    task automatic run_test(input int t);
        int cycles;
        cur_test = t;
        @(posedge clk);
        #1;
        reset = 1'b1;
        for (int i = 0; i < prog_len; i++) begin
            prog_mem[i] = prog_tab[t][i];
        end
        data_word = data_tab[t];
        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;
        // Run until active falls
        cycles = 0;
        @(negedge clk);
        while (active !== 1'b0 && cycles < halt_timeout) begin
            @(negedge clk);
            cycles++;
        end
        if (active !== 1'b0) begin
            timeouts++;
            $display("test %0d (%s) did not halt within %0d cycles",
                     t, name_tab[t], halt_timeout);
        end else begin
            repeat (halt_hold) begin          // Halted core stays idle
                @(negedge clk);
                check_value("active", active, 32'h0);
                check_value("read", read, 32'h0);
                check_value("write", write, 32'h0);
            end
            check_value("register_v0", register_v0, exp_v0_tab[t]);
            check_value("data word", data_word, exp_mem_tab[t]);
        end
    endtask

    initial begin
        clk         = 1'b0;
        reset       = 1'b1;
        waitrequest = 1'b0;
        readdata    = 32'h0;
        lcg_state   = 32'hd376;
        in_xfer     = 1'b0;
        stall_left  = 0;
        req_valid   = 1'b0;
        data_word   = 32'h0;
        errors      = 0;
        checks      = 0;
        timeouts    = 0;
        cur_test    = 0;
        for (int i = 0; i < prog_len; i++) begin
            prog_mem[i] = 32'h0;
        end
        build_table();
        for (int t = 0; t < n_tests; t++) begin
            run_test(t);
        end
        if (DUT.u_bus_assert.failures != 0) begin
            errors += DUT.u_bus_assert.failures;
            $display("bus protocol assertions fired %0d times", DUT.u_bus_assert.failures);
        end
        $display("%0d checks, %0d errors, %0d timeouts", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule
